//--- verification/aes_simd_core_tests.txt
// op rd rs1 rs2 load_data branch_taken scalar_wb vector_wb store_data, all hex
// vector results follow the first round of the FIPS-197 appendix B example
02 1 0 0 00000000000000000000000077771234 0 1234 0 0
02 2 0 0 ffff 0 ffff 0 0
02 3 0 0 00ff 0 00ff 0 0
02 4 0 0 0001 0 0001 0 0
02 5 0 0 000a 0 000a 0 0
04 6 1 0 0 0 1235 0 0
05 7 1 2 0 0 1233 0 0
06 8 1 3 0 0 12cb 0 0
07 9 1 3 0 0 21cc 0 0
07 a 2 2 0 0 0001 0 0
04 b 2 0 0 0 0000 0 0
03 0 1 2 0 1 0 0 0
03 c 4 4 0 0 0 0 0
01 0 9 0 0 0 0 0 21cc
12 1 0 0 3243f6a8885a308d313198a2e0370734 0 0 3243f6a8885a308d313198a2e0370734 0
12 2 0 0 2b7e151628aed2a6abf7158809cf4f3c 0 0 2b7e151628aed2a6abf7158809cf4f3c 0
13 3 1 2 0 0 0 193de3bea0f4e22b9ac68d2ae9f84808 0
12 4 0 0 d42711aee0bf98f1b8b45de51e415230 0 0 d42711aee0bf98f1b8b45de51e415230 0
14 5 4 0 0 0 0 d4bf5d30e0b452aeb84111f11e2798e5 0
15 6 5 0 0 0 0 046681e5e0cb199a48f8d37a2806264c 0
12 7 0 0 a0fafe1788542cb123a339392a6c7605 0 0 a0fafe1788542cb123a339392a6c7605 0
13 8 6 7 0 0 0 a49c7ff2689f352b6b5bea43026a5049 0
16 9 2 0 0 0 0 7e15162baed2a628f71588abcf4f3c09 0
12 a 0 0 8a84eb01000000000000000000000000 0 0 8a84eb01000000000000000000000000 0
17 b a 4 0 0 0 8b84eb01000000000000000000000000 0
17 c 2 5 0 0 0 1d7e151628aed2a6abf7158809cf4f3c 0
17 d 2 0 0 0 0 2b7e151628aed2a6abf7158809cf4f3c 0
11 0 8 0 0 0 0 0 a49c7ff2689f352b6b5bea43026a5049
00 1 1 2 0 0 0 0 0
1f 1 1 2 0 0 0 0 0
05 d 1 6 0 0 2469 0 0
11 0 1 0 0 0 0 0 3243f6a8885a308d313198a2e0370734

//--- aes_simd_core.f
source/aes_simd_pkg.sv
source/control_unit.sv
source/scalar_alu.sv
source/aes_vector_unit.sv
source/reg_bank.sv
source/aes_simd_core.sv
verification/aes_simd_core_checker.sv
verification/aes_simd_core_tb.sv

//--- Makefile
TOP = aes_simd_core_tb
SOURCES = $(wildcard source/*.sv) $(wildcard verification/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): aes_simd_core.f $(SOURCES)
	verilator --binary --timing --assert --top-module $(TOP) -f aes_simd_core.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f aes_simd_core.f

clean:
	rm -rf obj_dir

//--- verification/aes_simd_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module aes_simd_core_tb import aes_simd_pkg::*; ();

	localparam int NUM_REGS = DEFAULT_NUM_REGS;
	localparam int TIMEOUT = 50; // cycles allowed per handshake wait

	logic clk;
	logic rst;
	logic req;
	instr_t instr;
	logic ack;
	resp_t resp;

	scalar_t smodel [NUM_REGS]; // expected register contents
	vector_t vmodel [NUM_REGS];
	logic [31:0] rng;

	aes_simd_core #(.NUM_REGS(NUM_REGS)) i_aes_simd_core (
		.clk(clk),
		.rst(rst),
		.req(req),
		.instr(instr),
		.ack(ack),
		.resp(resp)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic stop_on_failure();
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_scalar(input string name, input scalar_t got, input scalar_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_vector(input string name, input vector_t got, input vector_t exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	// ack is sampled at the falling edge, the task returns on a rising edge
	task automatic wait_for_ack(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (ack !== level && cycles < TIMEOUT);
		if (ack !== level) begin
			if (level) begin
				$display("ack did not rise");
			end else begin
				$display("ack did not fall");
			end
			stop_on_failure();
		end
		@(posedge clk);
	endtask

	task automatic idle_gap();
		int n;
		rng = xorshift(rng);
		n = int'(rng[1:0]); // 0 to 3 cycles
		repeat (n) @(posedge clk);
	endtask

	// one four-phase transfer, req is held a random time after ack
	task automatic run_handshake(input instr_t ins, output resp_t got);
		idle_gap();
		req <= 1'b1;
		instr <= ins;
		wait_for_ack(1'b1);
		got = resp;
		idle_gap();
		req <= 1'b0;
		wait_for_ack(1'b0);
	endtask

	initial begin
		int fd;
		int n;
		int line_no;
		int tests_run;
		logic [8*256-1:0] line;
		logic [4:0] op_raw;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		vector_t load_data;
		logic exp_branch;
		scalar_t exp_scalar;
		vector_t exp_vector;
		vector_t exp_store;
		logic model_branch;
		scalar_t model_scalar;
		vector_t model_vector;
		vector_t model_store;
		instr_t ins;
		resp_t got;
		string tag;

		clk = 1'b0;
		rst = 1'b1;
		req = 1'b0;
		instr = '0;
		rng = 32'hfbc8_5265;
		for (int i = 0; i < NUM_REGS; i++) begin
			smodel[i] = '0;
			vmodel[i] = '0;
		end
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		fd = $fopen("verification/aes_simd_core_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open the tests file");
			stop_on_failure();
		end
		line_no = 0;
		tests_run = 0;
		while (!$feof(fd)) begin
			line = '0;
			n = $fgets(line, fd);
			line_no++;
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", op_raw, rd, rs1, rs2, load_data,
				exp_branch, exp_scalar, exp_vector, exp_store);
			if (n > 0 && n != 9) begin
				$display("line %0d of the tests file has %0d fields instead of 9", line_no, n);
				stop_on_failure();
			end
			if (n == 9) begin
				ins = '0;
				ins.op = opcode_t'(op_raw);
				ins.rd = rd;
				ins.rs1 = rs1;
				ins.rs2 = rs2;
				ins.load_data = load_data;

				// second opinion from the register model, aes steps only from the file
				model_branch = exp_branch;
				model_scalar = exp_scalar;
				model_vector = exp_vector;
				model_store = exp_store;
				case (ins.op)
					OP_LDR: model_scalar = load_data[SCALAR_W-1:0];
					OP_ADD1: model_scalar = smodel[rs1] + 16'd1;
					OP_ADD: model_scalar = smodel[rs1] + smodel[rs2];
					OP_XOR: model_scalar = smodel[rs1] ^ smodel[rs2];
					OP_MUL: model_scalar = smodel[rs1] * smodel[rs2]; // low half only
					OP_BNE: model_branch = (smodel[rs1] != smodel[rs2]);
					OP_STR: model_store = {{(VECTOR_W-SCALAR_W){1'b0}}, smodel[rs1]};
					OP_VLDR: model_vector = load_data;
					OP_ARK: model_vector = vmodel[rs1] ^ vmodel[rs2];
					OP_VSTR: model_store = vmodel[rs1];
					default: ;
				endcase

				run_handshake(ins, got);
				tests_run++;

				tag = $sformatf("line %0d", line_no);
				check_flag({tag, " resp.branch_taken"}, got.branch_taken, exp_branch);
				check_flag({tag, " resp.mem_we_scalar"}, got.mem_we_scalar, ins.op == OP_STR);
				check_flag({tag, " resp.mem_we_vector"}, got.mem_we_vector, ins.op == OP_VSTR);
				check_scalar({tag, " resp.scalar_wb"}, got.scalar_wb, exp_scalar);
				check_vector({tag, " resp.vector_wb"}, got.vector_wb, exp_vector);
				check_vector({tag, " resp.store_data"}, got.store_data, exp_store);
				check_flag({tag, " model branch_taken"}, got.branch_taken, model_branch);
				check_scalar({tag, " model scalar_wb"}, got.scalar_wb, model_scalar);
				check_vector({tag, " model vector_wb"}, got.vector_wb, model_vector);
				check_vector({tag, " model store_data"}, got.store_data, model_store);

				case (ins.op)
					OP_LDR, OP_ADD1, OP_ADD, OP_XOR, OP_MUL: smodel[rd] = exp_scalar;
					OP_VLDR, OP_ARK, OP_SHR, OP_MIX, OP_ROT, OP_RCON: vmodel[rd] = exp_vector;
					default: ; // stores, bne, nop and unknown leave both banks alone
				endcase
			end
		end
		$fclose(fd);

		if (tests_run == 0) begin
			$display("no instructions were found in the tests file");
			stop_on_failure();
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verification/aes_simd_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module aes_simd_core_checker import aes_simd_pkg::*; (
	input logic clk,
	input logic rst,
	input logic req,
	input logic ack,
	input resp_t resp
);

	ack_low_in_reset: assert property (@(posedge clk) rst |=> !ack)
		else $error("ack is high after a reset cycle");

	ack_rise_with_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> req)
		else $error("ack rose without a pending req");

	// ack holds until the requester lets go of req
	ack_held_until_req_low: assert property (@(posedge clk) disable iff (rst)
		ack && req |=> ack)
		else $error("ack dropped while req was still high");

	resp_stable_during_ack: assert property (@(posedge clk) disable iff (rst)
		ack && $past(ack) |-> $stable(resp))
		else $error("resp changed while ack was high");

endmodule

bind aes_simd_core aes_simd_core_checker i_aes_simd_core_checker (
	.clk(clk),
	.rst(rst),
	.req(req),
	.ack(ack),
	.resp(resp)
);

`default_nettype wire

//--- source/aes_simd_core.sv
`timescale 1ns/1ps
`default_nettype none

module aes_simd_core import aes_simd_pkg::*; #(
	parameter int NUM_REGS = DEFAULT_NUM_REGS
) (
	input logic clk,
	input logic rst,
	input logic req,
	input instr_t instr,
	output logic ack,
	output resp_t resp
);

	typedef enum logic [1:0] {IDLE, READ, EXEC, DONE} state_t;

	state_t state;
	ctrl_t ctrl_d;
	ctrl_t ctrl_q;
	instr_t instr_q;
	scalar_t s_rdata_a;
	scalar_t s_rdata_b;
	scalar_t s_op_a;
	scalar_t s_op_b;
	vector_t v_rdata_a;
	vector_t v_rdata_b;
	vector_t v_op_a;
	vector_t v_op_b;
	scalar_t alu_result;
	logic branch_taken;
	vector_t vec_result;
	resp_t resp_d;
	logic wb_cycle;

	control_unit i_control_unit (
		.op(instr.op),
		.ctrl(ctrl_d)
	);

	reg_bank #(.word_t(scalar_t), .NUM_REGS(NUM_REGS)) i_scalar_bank (
		.clk(clk),
		.rst(rst),
		.raddr_a(instr_q.rs1),
		.raddr_b(instr_q.rs2),
		.rdata_a(s_rdata_a),
		.rdata_b(s_rdata_b),
		.we(wb_cycle && ctrl_q.scalar_we),
		.waddr(instr_q.rd),
		.wdata(resp.scalar_wb)
	);

	reg_bank #(.word_t(vector_t), .NUM_REGS(NUM_REGS)) i_vector_bank (
		.clk(clk),
		.rst(rst),
		.raddr_a(instr_q.rs1),
		.raddr_b(instr_q.rs2),
		.rdata_a(v_rdata_a),
		.rdata_b(v_rdata_b),
		.we(wb_cycle && ctrl_q.vector_we),
		.waddr(instr_q.rd),
		.wdata(resp.vector_wb)
	);

	scalar_alu i_scalar_alu (
		.alu_op(ctrl_q.alu_op),
		.a(s_op_a),
		.b(s_op_b),
		.result(alu_result),
		.branch_taken(branch_taken)
	);

	aes_vector_unit i_aes_vector_unit (
		.vec_op(ctrl_q.vec_op),
		.a(v_op_a),
		.b(v_op_b),
		.round(s_op_b[$bits(reg_idx_t)-1:0]), // round number from scalar operand two
		.result(vec_result)
	);

	// first cycle in DONE, the write lands on the edge that raises ack
	assign wb_cycle = (state == DONE) && !ack;

	always_comb begin
		resp_d = '0;
		resp_d.branch_taken = branch_taken;
		resp_d.mem_we_scalar = ctrl_q.mem_we_scalar;
		resp_d.mem_we_vector = ctrl_q.mem_we_vector;
		if (ctrl_q.scalar_we) begin
			case (ctrl_q.wb_sel_scalar)
				WB_LOAD: resp_d.scalar_wb = ctrl_q.load ? instr_q.load_data[SCALAR_W-1:0] : '0;
				WB_UNIT: resp_d.scalar_wb = alu_result;
				default: resp_d.scalar_wb = '0;
			endcase
		end
		if (ctrl_q.vector_we) begin
			case (ctrl_q.wb_sel_vector)
				WB_LOAD: resp_d.vector_wb = ctrl_q.load ? instr_q.load_data : '0;
				WB_UNIT: resp_d.vector_wb = vec_result;
				default: resp_d.vector_wb = '0;
			endcase
		end
		if (ctrl_q.mem_we_scalar) begin
			resp_d.store_data = vector_t'(alu_result); // zero extended
		end else if (ctrl_q.mem_we_vector) begin
			resp_d.store_data = vec_result;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			ack <= 1'b0;
			ctrl_q <= '0;
			resp <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						ctrl_q <= ctrl_d;
						state <= READ;
					end
				end
				READ: state <= EXEC;
				EXEC: begin
					resp <= resp_d; // held through DONE
					state <= DONE;
				end
				DONE: begin
					if (!ack) begin
						ack <= 1'b1;
					end else if (!req) begin
						ack <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (state == IDLE && req) begin
			instr_q <= instr;
		end
		if (state == READ) begin
			s_op_a <= s_rdata_a;
			s_op_b <= s_rdata_b;
			v_op_a <= v_rdata_a;
			v_op_b <= v_rdata_b;
		end
	end

endmodule

`default_nettype wire

//--- source/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank import aes_simd_pkg::*; #(
	parameter type word_t = scalar_t,
	parameter int NUM_REGS = DEFAULT_NUM_REGS
) (
	input logic clk,
	input logic rst,
	input reg_idx_t raddr_a,
	input reg_idx_t raddr_b,
	output word_t rdata_a,
	output word_t rdata_b,
	input logic we,
	input reg_idx_t waddr,
	input word_t wdata
);

	word_t regs [NUM_REGS];

	// reads are combinational, indices past the bank read as zero
	assign rdata_a = (int'(raddr_a) < NUM_REGS) ? regs[raddr_a] : '0;
	assign rdata_b = (int'(raddr_b) < NUM_REGS) ? regs[raddr_b] : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (int'(waddr) < NUM_REGS)) begin
			regs[waddr] <= wdata;
		end
	end

endmodule

`default_nettype wire

//--- source/aes_vector_unit.sv
`timescale 1ns/1ps
`default_nettype none

module aes_vector_unit import aes_simd_pkg::*; (
	input vec_op_t vec_op,
	input vector_t a,
	input vector_t b,
	input reg_idx_t round,
	output vector_t result
);

	// multiply by x in GF(2^8), reduction polynomial 0x11b
	function automatic logic [7:0] xtime(input logic [7:0] x);
		return {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
	endfunction

	// byte i sits at bits VECTOR_W-1-8*i down, i = 4*column + row
	function automatic vector_t shift_rows(input vector_t s);
		vector_t t;
		t = '0;
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				// row r takes its byte from column c+r
				t[VECTOR_W-1-8*(4*c+r) -: 8] = s[VECTOR_W-1-8*(4*((c+r)%4)+r) -: 8];
			end
		end
		return t;
	endfunction

	function automatic logic [31:0] mix_column(input logic [31:0] col);
		logic [7:0] b0;
		logic [7:0] b1;
		logic [7:0] b2;
		logic [7:0] b3;
		b0 = col[31:24];
		b1 = col[23:16];
		b2 = col[15:8];
		b3 = col[7:0];
		// rows of the matrix 02 03 01 01, rotated
		return {xtime(b0) ^ xtime(b1) ^ b1 ^ b2 ^ b3,
			b0 ^ xtime(b1) ^ xtime(b2) ^ b2 ^ b3,
			b0 ^ b1 ^ xtime(b2) ^ xtime(b3) ^ b3,
			xtime(b0) ^ b0 ^ b1 ^ b2 ^ xtime(b3)};
	endfunction

	function automatic vector_t mix_columns(input vector_t s);
		vector_t t;
		t = '0;
		for (int c = 0; c < 4; c++) begin
			t[VECTOR_W-1-32*c -: 32] = mix_column(s[VECTOR_W-1-32*c -: 32]);
		end
		return t;
	endfunction

	function automatic logic [7:0] rcon(input reg_idx_t round_num);
		case (round_num)
			4'd1: return 8'h01;
			4'd2: return 8'h02;
			4'd3: return 8'h04;
			4'd4: return 8'h08;
			4'd5: return 8'h10;
			4'd6: return 8'h20;
			4'd7: return 8'h40;
			4'd8: return 8'h80;
			4'd9: return 8'h1b;
			4'd10: return 8'h36;
			default: return 8'h00; // no constant outside rounds 1 to 10
		endcase
	endfunction

	always_comb begin
		result = '0;
		case (vec_op)
			VEC_STR: result = a; // store data
			VEC_ARK: result = a ^ b;
			VEC_SHR: result = shift_rows(a);
			VEC_MIX: result = mix_columns(a);
			VEC_ROT: begin
				// each column word rotated left by one byte
				for (int c = 0; c < 4; c++) begin
					result[VECTOR_W-1-32*c -: 32] = {a[VECTOR_W-9-32*c -: 24],
						a[VECTOR_W-1-32*c -: 8]};
				end
			end
			VEC_RCON: begin
				result = a;
				result[VECTOR_W-1 -: 8] = a[VECTOR_W-1 -: 8] ^ rcon(round);
			end
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/scalar_alu.sv
`timescale 1ns/1ps
`default_nettype none

module scalar_alu import aes_simd_pkg::*; (
	input alu_op_t alu_op,
	input scalar_t a,
	input scalar_t b,
	output scalar_t result,
	output logic branch_taken
);

	logic [2*SCALAR_W-1:0] product;

	// full width product, only the low half is kept
	assign product = {{SCALAR_W{1'b0}}, a} * {{SCALAR_W{1'b0}}, b};

	always_comb begin
		result = '0;
		branch_taken = 1'b0;
		case (alu_op)
			ALU_STR: result = a; // store data passes through
			ALU_ADD1: result = a + scalar_t'(1);
			ALU_ADD: result = a + b; // wraps at 16 bits
			ALU_XOR: result = a ^ b;
			ALU_MUL: result = product[SCALAR_W-1:0];
			ALU_BNE: branch_taken = (a != b);
			default: begin
				result = '0;
				branch_taken = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import aes_simd_pkg::*; (
	input opcode_t op,
	output ctrl_t ctrl
);

	always_comb begin
		ctrl = '0; // nop and anything not decoded below
		case (op)
			// scalar store, data comes out of the alu
			OP_STR: begin
				ctrl.mem_we_scalar = 1'b1;
				ctrl.alu_op = ALU_STR;
			end
			OP_LDR: begin
				ctrl.load = 1'b1;
				ctrl.scalar_we = 1'b1;
				ctrl.wb_sel_scalar = WB_LOAD;
				ctrl.alu_op = ALU_LDR;
			end
			OP_BNE: begin
				ctrl.alu_op = ALU_BNE; // compare only, no writeback
			end
			OP_ADD1: begin
				ctrl.scalar_we = 1'b1;
				ctrl.wb_sel_scalar = WB_UNIT;
				ctrl.alu_op = ALU_ADD1;
			end
			OP_ADD: begin
				ctrl.scalar_we = 1'b1;
				ctrl.wb_sel_scalar = WB_UNIT;
				ctrl.alu_op = ALU_ADD;
			end
			OP_XOR: begin
				ctrl.scalar_we = 1'b1;
				ctrl.wb_sel_scalar = WB_UNIT;
				ctrl.alu_op = ALU_XOR;
			end
			OP_MUL: begin
				ctrl.scalar_we = 1'b1;
				ctrl.wb_sel_scalar = WB_UNIT;
				ctrl.alu_op = ALU_MUL;
			end
			OP_VSTR: begin
				ctrl.mem_we_vector = 1'b1;
				ctrl.vec_op = VEC_STR;
			end
			OP_VLDR: begin
				ctrl.load = 1'b1;
				ctrl.vector_we = 1'b1;
				ctrl.wb_sel_vector = WB_LOAD;
				ctrl.vec_op = VEC_LDR;
			end
			// aes round steps all write the vector result back
			OP_ARK, OP_SHR, OP_MIX, OP_ROT, OP_RCON: begin
				ctrl.vector_we = 1'b1;
				ctrl.wb_sel_vector = WB_UNIT;
				case (op)
					OP_ARK: ctrl.vec_op = VEC_ARK;
					OP_SHR: ctrl.vec_op = VEC_SHR;
					OP_MIX: ctrl.vec_op = VEC_MIX;
					OP_ROT: ctrl.vec_op = VEC_ROT;
					default: ctrl.vec_op = VEC_RCON;
				endcase
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- source/aes_simd_pkg.sv
`default_nettype none

package aes_simd_pkg;

	localparam int SCALAR_W = 16;
	localparam int VECTOR_W = 128;
	localparam int DEFAULT_NUM_REGS = 16;

	typedef logic [SCALAR_W-1:0] scalar_t;
	typedef logic [VECTOR_W-1:0] vector_t; // byte 0 in 127:120, column major
	typedef logic [3:0] reg_idx_t;

	// scalar opcodes have bit 4 clear, vector opcodes have it set
	typedef enum logic [4:0] {
		OP_NOP  = 5'b00000,
		OP_STR  = 5'b00001,
		OP_LDR  = 5'b00010,
		OP_BNE  = 5'b00011,
		OP_ADD1 = 5'b00100,
		OP_ADD  = 5'b00101,
		OP_XOR  = 5'b00110,
		OP_MUL  = 5'b00111,
		OP_VSTR = 5'b10001,
		OP_VLDR = 5'b10010,
		OP_ARK  = 5'b10011,
		OP_SHR  = 5'b10100,
		OP_MIX  = 5'b10101,
		OP_ROT  = 5'b10110,
		OP_RCON = 5'b10111
	} opcode_t;

	typedef enum logic [4:0] {
		ALU_NOP  = 5'b00000,
		ALU_STR  = 5'b00001,
		ALU_LDR  = 5'b00010,
		ALU_BNE  = 5'b00011,
		ALU_ADD1 = 5'b00100,
		ALU_ADD  = 5'b00101,
		ALU_XOR  = 5'b00110,
		ALU_MUL  = 5'b00111
	} alu_op_t;

	typedef enum logic [4:0] {
		VEC_NOP  = 5'b00000,
		VEC_STR  = 5'b10001,
		VEC_LDR  = 5'b10010,
		VEC_ARK  = 5'b10011,
		VEC_SHR  = 5'b10100,
		VEC_MIX  = 5'b10101,
		VEC_ROT  = 5'b10110,
		VEC_RCON = 5'b10111
	} vec_op_t;

	// writeback source select
	localparam logic [1:0] WB_LOAD = 2'b00;
	localparam logic [1:0] WB_UNIT = 2'b01;

	typedef struct packed {
		opcode_t op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		vector_t load_data; // read data for ldr and vldr
	} instr_t;

	typedef struct packed {
		logic load;
		logic scalar_we;
		logic vector_we;
		logic mem_we_scalar;
		logic mem_we_vector;
		logic [1:0] wb_sel_scalar;
		logic [1:0] wb_sel_vector;
		alu_op_t alu_op;
		vec_op_t vec_op;
	} ctrl_t;

	typedef struct packed {
		logic branch_taken;
		logic mem_we_scalar;
		logic mem_we_vector;
		scalar_t scalar_wb;
		vector_t vector_wb;
		vector_t store_data;
	} resp_t;

endpackage

`default_nettype wire
